// File: rtl/rvDefines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// RV32I opcodes
`define TYPE_R       7'b0110011
`define TYPE_I       7'b0010011
`define TYPE_I_LOAD  7'b0000011
`define TYPE_I_JALR  7'b1100111
`define TYPE_S       7'b0100011
`define TYPE_B       7'b1100011
`define TYPE_J       7'b1101111
`define TYPE_U_LUI   7'b0110111
`define TYPE_U_AUIPC 7'b0010111
`define TYPE_SYSTEM  7'b1110011

// immediate formats
`define IMM_I 3'd0
`define IMM_S 3'd1
`define IMM_B 3'd2
`define IMM_U 3'd3
`define IMM_J 3'd4

// alu operations
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLL  4'd2
`define ALU_SLT  4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_OR   4'd8
`define ALU_AND  4'd9
`define ALU_LUI  4'd10

// operand b sources
`define BSRC_RS2  2'd0
`define BSRC_IMM  2'd1
`define BSRC_FOUR 2'd2

`define NUM_REGS 32

`endif

// File: rtl/rvPkg.sv
`default_nettype none

package rvPkg;

    // data word, address or pc
    typedef logic [31:0] wordT;

    typedef logic [4:0] regAddrT;

    typedef logic [3:0] aluSelT;

    typedef logic [2:0] immKindT;

    // core stops accepting once halted
    typedef enum logic {
        RUNNING,
        HALTED
    } runStateT;

endpackage

`default_nettype wire

// File: rtl/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvDefines.svh"

module controlUnit import rvPkg::*; (
    input  wire [6:0] opcode,
    input  wire [2:0] funct3,
    input  wire       funct7b,
    output immKindT   immKind,
    output aluSelT    aluSel,
    output logic      aluASrcPc,
    output logic [1:0] aluBSrc,
    output logic      regWrite,
    output logic      isBranch,
    output logic      isJal,
    output logic      isJalr,
    output logic      isLoad,
    output logic      isStore,
    output logic      isHalt
);

    logic typeR, typeI, typeS, typeB, typeLui, typeAuipc;
    aluSelT riSel, bSel;

    // opcode classes
    assign typeR     = (opcode == `TYPE_R);
    assign typeI     = (opcode == `TYPE_I);
    assign typeS     = (opcode == `TYPE_S);
    assign typeB     = (opcode == `TYPE_B);
    assign typeLui   = (opcode == `TYPE_U_LUI);
    assign typeAuipc = (opcode == `TYPE_U_AUIPC);
    assign isJal     = (opcode == `TYPE_J);
    assign isJalr    = (opcode == `TYPE_I_JALR);
    assign isLoad    = (opcode == `TYPE_I_LOAD);
    assign isStore   = typeS;
    assign isBranch  = typeB;
    assign isHalt    = (opcode == `TYPE_SYSTEM) && (funct3 == 3'b000) && !funct7b;

    assign immKind = (typeLui || typeAuipc) ? `IMM_U :
                     typeB                  ? `IMM_B :
                     typeS                  ? `IMM_S :
                     isJal                  ? `IMM_J : `IMM_I;

    assign regWrite = typeR || typeI || isLoad || isJal || isJalr || typeLui || typeAuipc;

    // jumps compute the link value pc+4 in the alu
    assign aluASrcPc = typeAuipc || isJal || isJalr;
    assign aluBSrc   = (isJal || isJalr)                                   ? `BSRC_FOUR :
                       (typeI || isLoad || typeS || typeLui || typeAuipc) ? `BSRC_IMM  :
                                                                            `BSRC_RS2;

    always_comb begin
        case (funct3)
            3'b000:  riSel = (typeR && funct7b) ? `ALU_SUB : `ALU_ADD;
            3'b001:  riSel = `ALU_SLL;
            3'b010:  riSel = `ALU_SLT;
            3'b011:  riSel = `ALU_SLTU;
            3'b100:  riSel = `ALU_XOR;
            3'b101:  riSel = funct7b ? `ALU_SRA : `ALU_SRL;
            3'b110:  riSel = `ALU_OR;
            default: riSel = `ALU_AND;
        endcase
    end

    // beq/bne compare by subtract, blt/bge signed, bltu/bgeu unsigned
    assign bSel = (funct3[2] && funct3[1]) ? `ALU_SLTU :
                  (funct3[2] ^ funct3[1])  ? `ALU_SLT  : `ALU_SUB;

    assign aluSel = typeB              ? bSel     :
                    typeLui            ? `ALU_LUI :
                    (typeR || typeI)   ? riSel    : `ALU_ADD;

endmodule

`default_nettype wire

// File: rtl/immGen.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvDefines.svh"

module immGen import rvPkg::*; (
    input  wire wordT    instr,
    input  wire immKindT immKind,
    output wordT         imm
);

    always_comb begin
        case (immKind)
            `IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            `IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // b and j offsets are in halfwords
            `IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            `IMM_U: imm = {instr[31:12], 12'b0};
            `IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvDefines.svh"

module alu import rvPkg::*; (
    input  wire wordT   a,
    input  wire wordT   b,
    input  wire aluSelT aluSel,
    output wordT        result,
    output logic        zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluSel)
            `ALU_ADD:  result = a + b;
            `ALU_SUB:  result = a - b;
            `ALU_SLL:  result = a << shamt;
            `ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            `ALU_SLTU: result = {31'b0, a < b};
            `ALU_XOR:  result = a ^ b;
            `ALU_SRL:  result = a >> shamt;
            `ALU_SRA:  result = $signed(a) >>> shamt;
            `ALU_OR:   result = a | b;
            `ALU_AND:  result = a & b;
            // lui passes the immediate through
            `ALU_LUI:  result = b;
            default:   result = '0;
        endcase
    end

    // used for beq/bne
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvDefines.svh"

module regFile import rvPkg::*; (
    input  wire          clk,
    input  wire          arstN,
    input  wire regAddrT rs1Addr,
    input  wire regAddrT rs2Addr,
    input  wire          we,
    input  wire regAddrT rdAddr,
    input  wire wordT    rdData,
    output wordT         rs1Data,
    output wordT         rs2Data
);

    // x0 has no storage
    wordT regs [1:`NUM_REGS-1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rdAddr != '0)) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// File: rtl/execCore.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvDefines.svh"

module execCore import rvPkg::*; (
    input  wire       clk,
    input  wire       arstN,
    input  wire       instrValid,
    input  wire wordT instr,
    input  wire wordT pc,
    output logic      instrReady,
    output logic      resValid,
    output logic      resWe,
    output regAddrT   resRd,
    output wordT      resValue,
    output wordT      resNextPc,
    output logic      resMemEn,
    output logic      resMemWrite,
    output wordT      resMemAddr,
    output wordT      resMemData,
    input  wire       resReady,
    output logic      halted
);

    immKindT immKind;
    aluSelT aluSel;
    logic aluASrcPc;
    logic [1:0] aluBSrc;
    logic regWrite, isBranch, isJal, isJalr, isLoad, isStore, isHalt;
    wordT imm, rs1Data, rs2Data, aluA, aluB, aluResult;
    wordT pcPlus4, pcTarget, jalrSum, nextPc;
    logic aluZero, cond, taken, accept;
    runStateT state;

    controlUnit i_controlUnit (
        .opcode    (instr[6:0]),
        .funct3    (instr[14:12]),
        .funct7b   (instr[30]),
        .immKind   (immKind),
        .aluSel    (aluSel),
        .aluASrcPc (aluASrcPc),
        .aluBSrc   (aluBSrc),
        .regWrite  (regWrite),
        .isBranch  (isBranch),
        .isJal     (isJal),
        .isJalr    (isJalr),
        .isLoad    (isLoad),
        .isStore   (isStore),
        .isHalt    (isHalt)
    );

    immGen i_immGen (
        .instr   (instr),
        .immKind (immKind),
        .imm     (imm)
    );

    regFile i_regFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (instr[19:15]),
        .rs2Addr (instr[24:20]),
        .we      (accept && regWrite),
        .rdAddr  (instr[11:7]),
        .rdData  (aluResult),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign aluA = aluASrcPc ? pc : rs1Data;
    assign aluB = (aluBSrc == `BSRC_FOUR) ? 32'd4 :
                  (aluBSrc == `BSRC_IMM)  ? imm   : rs2Data;

    alu i_alu (
        .a      (aluA),
        .b      (aluB),
        .aluSel (aluSel),
        .result (aluResult),
        .zero   (aluZero)
    );

    // funct3[2] picks less-than over equal, funct3[0] inverts the sense
    assign cond  = instr[14] ? aluResult[0] : aluZero;
    assign taken = isBranch && (cond ^ instr[12]);

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;
    assign jalrSum  = rs1Data + imm;
    assign nextPc   = isJalr             ? {jalrSum[31:1], 1'b0} :
                      (isJal || taken)   ? pcTarget              : pcPlus4;

    // a new instruction may enter while the previous result leaves
    assign instrReady = (state == RUNNING) && (!resValid || resReady);
    assign accept     = instrValid && instrReady;
    assign halted     = (state == HALTED);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= RUNNING;
            resValid <= 1'b0;
        end else begin
            if (accept) begin
                resValid <= 1'b1;
            end else if (resReady) begin
                resValid <= 1'b0;
            end
            if (accept && isHalt) begin
                state <= HALTED;
            end
        end
    end

    // loads report their address as the writeback value
    always_ff @(posedge clk) begin
        if (accept) begin
            resWe       <= regWrite;
            resRd       <= instr[11:7];
            resValue    <= aluResult;
            resNextPc   <= nextPc;
            resMemEn    <= isLoad || isStore;
            resMemWrite <= isStore;
            resMemAddr  <= (isLoad || isStore) ? aluResult : '0;
            resMemData  <= isStore ? rs2Data : '0;
        end
    end

endmodule

`default_nettype wire

// File: verification/execChecker.sv
`timescale 1ns/1ns
`default_nettype none

module execChecker import rvPkg::*; (
    input  wire          clk,
    input  wire          arstN,
    input  wire          instrReady,
    input  wire          resValid,
    input  wire          resReady,
    input  wire          resWe,
    input  wire regAddrT resRd,
    input  wire wordT    resValue,
    input  wire wordT    resNextPc,
    input  wire          resMemEn,
    input  wire          resMemWrite,
    input  wire wordT    resMemAddr,
    input  wire wordT    resMemData,
    input  wire          halted,
    output int           testCount,
    output int           errorCount
);

    integer fd;
    logic [31:0] expCol [0:10];
    logic [135:0] fields;
    logic [135:0] heldFields;
    logic wasStalled;
    logic lineBad;

    assign fields = {resWe, resRd, resValue, resNextPc, resMemEn, resMemWrite,
                     resMemAddr, resMemData};

    initial begin
        testCount  = 0;
        errorCount = 0;
        wasStalled = 1'b0;
        fd = $fopen("verification/execCore_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            errorCount++;
        end
    end

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("error %s expected %h actual %h", name, expVal, actVal);
            errorCount++;
            lineBad = 1'b1;
        end
    endtask

    task automatic checkResult();
        lineBad = 1'b0;
        testCount++;
        if (fd == 0 || $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                expCol[0], expCol[1], expCol[2], expCol[3], expCol[4], expCol[5],
                expCol[6], expCol[7], expCol[8], expCol[9], expCol[10]) != 11) begin
            $display("result %0d arrived with no trace line left", testCount);
            errorCount++;
        end else begin
            // rd and value only mean something on a writeback
            if (expCol[2][0]) begin
                checkField("resRd", expCol[3], resRd);
                checkField("resValue", expCol[4], resValue);
            end
            checkField("resWe", expCol[2], resWe);
            checkField("resNextPc", expCol[5], resNextPc);
            checkField("resMemEn", expCol[6], resMemEn);
            checkField("resMemWrite", expCol[7], resMemWrite);
            checkField("resMemAddr", expCol[8], resMemAddr);
            checkField("resMemData", expCol[9], resMemData);
            checkField("halted", expCol[10], halted);
            $display("test %0d instr %h pc %h %s", testCount, expCol[0], expCol[1],
                     lineBad ? "mismatch" : "ok");
        end
    endtask

    // negedge sampling, handshake completes on the next rising edge
    always @(negedge clk) begin
        if (arstN) begin
            if (wasStalled && (!resValid || fields !== heldFields)) begin
                $display("result changed while the output was stalled");
                errorCount++;
            end
            if (halted && instrReady) begin
                $display("instrReady is high although the core has halted");
                errorCount++;
            end
            if (resValid && resReady) begin
                checkResult();
            end
            wasStalled = resValid && !resReady;
            heldFields = fields;
        end
    end

endmodule

`default_nettype wire

// File: verification/tbExecCore.sv
`timescale 1ns/1ns
`default_nettype none

module tbExecCore import rvPkg::*; ();

    localparam int READY_TIMEOUT  = 50;
    localparam int RESULT_TIMEOUT = 200;

    logic clk;
    logic arstN;
    logic instrValid;
    wordT instr;
    wordT pc;
    logic instrReady;
    logic resValid;
    logic resWe;
    regAddrT resRd;
    wordT resValue;
    wordT resNextPc;
    logic resMemEn;
    logic resMemWrite;
    wordT resMemAddr;
    wordT resMemData;
    logic resReady;
    logic halted;
    int testCount;
    int errorCount;
    integer fd;
    wordT col [0:10];
    int sent;
    int waited;
    string reason;
    logic [31:0] lcgState = 32'h39b4_9376;

    execCore i_dut (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .instrReady  (instrReady),
        .resValid    (resValid),
        .resWe       (resWe),
        .resRd       (resRd),
        .resValue    (resValue),
        .resNextPc   (resNextPc),
        .resMemEn    (resMemEn),
        .resMemWrite (resMemWrite),
        .resMemAddr  (resMemAddr),
        .resMemData  (resMemData),
        .resReady    (resReady),
        .halted      (halted)
    );

    execChecker i_checker (
        .clk         (clk),
        .arstN       (arstN),
        .instrReady  (instrReady),
        .resValid    (resValid),
        .resReady    (resReady),
        .resWe       (resWe),
        .resRd       (resRd),
        .resValue    (resValue),
        .resNextPc   (resNextPc),
        .resMemEn    (resMemEn),
        .resMemWrite (resMemWrite),
        .resMemAddr  (resMemAddr),
        .resMemData  (resMemData),
        .halted      (halted),
        .testCount   (testCount),
        .errorCount  (errorCount)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // ready about three cycles in four
    always @(posedge clk) begin
        resReady <= (nextRandom() >= 32'h4000_0000);
    end

    task automatic finishRun(input string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("tests %0d, errors %0d", testCount, errorCount);
        if (why == "" && errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        resReady   = 1'b0;
        sent       = 0;
        reason     = "";
        fd = $fopen("verification/execCore_trace.txt", "r");
        if (fd == 0) begin
            reason = "could not open the trace file";
        end
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        while (reason == "" && $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                col[8], col[9], col[10]) == 11) begin
            instrValid <= 1'b1;
            instr      <= col[0];
            pc         <= col[1];
            sent++;
            waited = 0;
            @(negedge clk);
            while (!instrReady && waited < READY_TIMEOUT) begin
                waited++;
                @(negedge clk);
            end
            if (!instrReady) begin
                reason = $sformatf("timeout: instruction %0d was never accepted", sent);
            end else begin
                @(posedge clk);
            end
        end
        // keep offering an addi after the halt
        instrValid <= 1'b1;
        instr      <= 32'h0010_0093;
        pc         <= pc + 32'd4;
        waited = 0;
        while (reason == "" && testCount < sent && waited < RESULT_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (reason == "" && testCount < sent) begin
            reason = $sformatf("timeout: no result arrived for instruction %0d",
                               testCount + 1);
        end
        repeat (10) @(posedge clk);
        finishRun(reason);
    end

endmodule

`default_nettype wire

// File: verification/execCore_trace.txt
00500093 00000100 1 01 00000005 00000104 0 0 00000000 00000000 0
ffd00113 00000104 1 02 fffffffd 00000108 0 0 00000000 00000000 0
002081b3 00000108 1 03 00000002 0000010c 0 0 00000000 00000000 0
40208233 0000010c 1 04 00000008 00000110 0 0 00000000 00000000 0
004092b3 00000110 1 05 00000500 00000114 0 0 00000000 00000000 0
40115333 00000114 1 06 ffffffff 00000118 0 0 00000000 00000000 0
00415393 00000118 1 07 0fffffff 0000011c 0 0 00000000 00000000 0
00112433 0000011c 1 08 00000001 00000120 0 0 00000000 00000000 0
001134b3 00000120 1 09 00000000 00000124 0 0 00000000 00000000 0
0ff2c513 00000124 1 0a 000005ff 00000128 0 0 00000000 00000000 0
001265b3 00000128 1 0b 0000000d 0000012c 0 0 00000000 00000000 0
7f017613 0000012c 1 0c 000007f0 00000130 0 0 00000000 00000000 0
123456b7 00000130 1 0d 12345000 00000134 0 0 00000000 00000000 0
00001717 00000134 1 0e 00001134 00000138 0 0 00000000 00000000 0
010007ef 00000138 1 0f 0000013c 00000148 0 0 00000000 00000000 0
00560867 0000013c 1 10 00000140 000007f4 0 0 00000000 00000000 0
fe048ce3 00000140 0 00 00000000 00000138 0 0 00000000 00000000 0
00808463 00000144 0 00 00000000 00000148 0 0 00000000 00000000 0
00809463 00000148 0 00 00000000 00000150 0 0 00000000 00000000 0
00049463 0000014c 0 00 00000000 00000150 0 0 00000000 00000000 0
fe114ce3 00000150 0 00 00000000 00000148 0 0 00000000 00000000 0
0020c463 00000154 0 00 00000000 00000158 0 0 00000000 00000000 0
0020d463 00000158 0 00 00000000 00000160 0 0 00000000 00000000 0
00115463 0000015c 0 00 00000000 00000160 0 0 00000000 00000000 0
fe20ece3 00000160 0 00 00000000 00000158 0 0 00000000 00000000 0
00116463 00000164 0 00 00000000 00000168 0 0 00000000 00000000 0
00117463 00000168 0 00 00000000 00000170 0 0 00000000 00000000 0
0020f463 0000016c 0 00 00000000 00000170 0 0 00000000 00000000 0
00d62623 00000170 0 00 00000000 00000174 1 1 000007fc 12345000 0
ff06a883 00000174 1 11 12344ff0 00000178 1 0 12344ff0 00000000 0
0040a003 00000178 1 00 00000009 0000017c 1 0 00000009 00000000 0
01100933 0000017c 1 12 12344ff0 00000180 0 0 00000000 00000000 0
00000073 00000180 0 00 00000000 00000184 0 0 00000000 00000000 1

// File: tb.f
+incdir+rtl
rtl/rvPkg.sv
rtl/controlUnit.sv
rtl/immGen.sv
rtl/alu.sv
rtl/regFile.sv
rtl/execCore.sv
verification/execChecker.sv
verification/tbExecCore.sv

// File: Bender.yml
package:
  name: execCore

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rvPkg.sv
      - rtl/controlUnit.sv
      - rtl/immGen.sv
      - rtl/alu.sv
      - rtl/regFile.sv
      - rtl/execCore.sv
  - target: simulation
    files:
      - verification/execChecker.sv
      - verification/tbExecCore.sv
